// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int csr_w      = 12;
    localparam int uop_w      = 6;

    // major opcodes
    localparam logic [opcode_w-1:0] op_reg      = 7'b01_100_11;
    localparam logic [opcode_w-1:0] op_imm      = 7'b00_100_11;
    localparam logic [opcode_w-1:0] op_auipc    = 7'b00_101_11;
    localparam logic [opcode_w-1:0] op_jal      = 7'b11_011_11;
    localparam logic [opcode_w-1:0] op_jalr     = 7'b11_001_11;
    localparam logic [opcode_w-1:0] op_branch   = 7'b11_000_11;
    localparam logic [opcode_w-1:0] op_lui      = 7'b01_101_11;
    localparam logic [opcode_w-1:0] op_load     = 7'b00_000_11;
    localparam logic [opcode_w-1:0] op_store    = 7'b01_000_11;
    localparam logic [opcode_w-1:0] op_misc_mem = 7'b00_011_11;
    localparam logic [opcode_w-1:0] op_system   = 7'b11_100_11;

    // funct7 qualifiers
    localparam logic [funct7_w-1:0] f7_base   = 7'b0000000;
    localparam logic [funct7_w-1:0] f7_alt    = 7'b0100000;
    localparam logic [funct7_w-1:0] f7_muldiv = 7'b0000001;

    // field start bits
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs_lsb     = 15;
    localparam int rt_lsb     = 20;
    localparam int funct7_lsb = 25;

    localparam logic [uop_w-1:0] uop_illegal = 6'd63;

    // register read request bits
    localparam logic [1:0] req_rs = 2'b01;
    localparam logic [1:0] req_rt = 2'b10;

    typedef enum logic [3:0] {
        cls_alu, cls_alu_alt, cls_mul, cls_div,
        cls_alu_imm, cls_sra_imm,
        cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_lui, cls_load, cls_store, cls_fence, cls_system,
        cls_illegal
    } instr_class_t;

    typedef enum logic [2:0] {
        fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
    } fmt_t;

    // execution pipes
    typedef enum logic [1:0] {
        pipe_x, pipe_d, pipe_l, pipe_c
    } pipe_t;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        pipe_t                 pipe;
        logic [uop_w-1:0]      uop;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [1:0]            req;
        logic [xlen-1:0]       imm;
        logic [csr_w-1:0]      csr;
        logic [xlen-1:0]       pc;
        // debug only
        instr_class_t          cls;
        fmt_t                  fmt;
    } dec_pkt_t;

endpackage

`default_nettype wire

// ==== pipe_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_pkt,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_pkt,
    input  logic     out_ready
);

    logic     full;
    payload_t pkt_q;

    // take a new item when empty or when the held one leaves this cycle
    assign in_ready  = (!full || out_ready) && !flush;
    assign out_valid = full;
    assign out_pkt   = pkt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pkt_q <= in_pkt;
        end
    end

    // held item must not move under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && !flush |=> $stable(out_pkt));

    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !out_valid);

endmodule

`default_nettype wire

// ==== opcode_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_classify import decode_pkg::*; (
    input  logic [xlen-1:0] instr,
    output instr_class_t    cls,
    output fmt_t            fmt
);

    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;

    assign opcode = instr[opcode_w-1:0];
    assign funct3 = instr[funct3_lsb +: funct3_w];
    assign funct7 = instr[funct7_lsb +: funct7_w];

    always_comb begin
        unique case (opcode)
            op_reg: begin
                if (funct7 == f7_base) begin
                    cls = cls_alu;
                end else if (funct7 == f7_alt) begin
                    cls = cls_alu_alt;
                end else if (funct7 == f7_muldiv) begin
                    // upper half of funct3 is the divide group
                    cls = funct3[2] ? cls_div : cls_mul;
                end else begin
                    cls = cls_illegal;
                end
            end
            op_imm: begin
                if (funct3 == 3'd5 && funct7 == f7_alt) begin
                    cls = cls_sra_imm;
                end else begin
                    cls = cls_alu_imm;
                end
            end
            op_auipc:    cls = cls_auipc;
            op_jal:      cls = cls_jal;
            op_jalr:     cls = cls_jalr;
            op_branch:   cls = cls_branch;
            op_lui:      cls = cls_lui;
            op_load:     cls = cls_load;
            op_store:    cls = cls_store;
            op_misc_mem: cls = cls_fence;
            op_system:   cls = cls_system;
            default:     cls = cls_illegal;
        endcase
    end

    // encoding format per class
    always_comb begin
        unique case (cls)
            cls_alu_imm, cls_sra_imm, cls_jalr, cls_lui,
            cls_load, cls_fence, cls_system: fmt = fmt_i;
            cls_store:                       fmt = fmt_s;
            cls_branch:                      fmt = fmt_b;
            cls_auipc:                       fmt = fmt_u;
            cls_jal:                         fmt = fmt_j;
            default:                         fmt = fmt_r;
        endcase
    end

endmodule

`default_nettype wire

// ==== uop_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_map import decode_pkg::*; (
    input  instr_class_t     cls,
    input  logic [xlen-1:0]  instr,
    output pipe_t            pipe,
    output logic [uop_w-1:0] uop
);

    logic [funct3_w-1:0] funct3;
    logic [csr_w-1:0]    sys_field;

    assign funct3    = instr[funct3_lsb +: funct3_w];
    assign sys_field = instr[rt_lsb +: csr_w];

    always_comb begin
        logic [2:0] grp;
        logic [2:0] low;

        pipe = pipe_x;
        grp  = 3'd0;
        low  = funct3;
        unique case (cls)
            cls_alu: begin
                grp = 3'd0;
            end
            cls_alu_alt: begin
                grp = 3'd1;
                low = (funct3 == 3'd0) ? 3'd4 : 3'd5;
            end
            cls_mul: begin
                grp = 3'd1;
            end
            cls_alu_imm: begin
                grp = 3'd2;
            end
            cls_sra_imm: begin
                grp = 3'd3;
                low = 3'd2;
            end
            cls_branch: begin
                grp = 3'd3;
            end
            cls_auipc: begin
                grp = 3'd4;
                low = 3'd0;
            end
            cls_jal: begin
                grp = 3'd4;
                low = 3'd1;
            end
            cls_jalr: begin
                grp = 3'd4;
                low = 3'd2;
            end
            cls_div: begin
                pipe = pipe_d;
            end
            cls_load: begin
                pipe = pipe_l;
            end
            cls_lui: begin
                pipe = pipe_l;
                low  = 3'd3;
            end
            cls_store: begin
                pipe = pipe_l;
                grp  = 3'd1;
            end
            cls_fence: begin
                pipe = pipe_l;
                grp  = 3'd2;
            end
            cls_system: begin
                pipe = pipe_c;
                if (funct3 == 3'd0) begin
                    // ecall vs ebreak
                    low = (sys_field == 12'd1) ? 3'd1 : 3'd0;
                end else begin
                    grp = 3'd1;
                end
            end
            default: begin
                grp = uop_illegal[5:3];
                low = uop_illegal[2:0];
            end
        endcase

        uop = {grp, low};

        // group 7 is reserved for illegal encodings only
        assert ((uop == uop_illegal) == (cls == cls_illegal))
            else $error("uop_map: illegal uop mismatch, cls %0d uop %0d", cls, uop);
    end

endmodule

`default_nettype wire

// ==== operand_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_extract import decode_pkg::*; (
    input  fmt_t                  fmt,
    input  logic [xlen-1:0]       instr,
    output logic [reg_addr_w-1:0] rd,
    output logic [reg_addr_w-1:0] rs,
    output logic [reg_addr_w-1:0] rt,
    output logic [1:0]            req,
    output logic [xlen-1:0]       imm,
    output logic [csr_w-1:0]      csr
);

    logic use_rd;
    logic use_rs;
    logic use_rt;
    logic sign;

    assign use_rd = (fmt == fmt_r) || (fmt == fmt_i) || (fmt == fmt_u) || (fmt == fmt_j);
    assign use_rs = (fmt == fmt_r) || (fmt == fmt_i) || (fmt == fmt_s) || (fmt == fmt_b);
    assign use_rt = (fmt == fmt_r) || (fmt == fmt_s) || (fmt == fmt_b);

    // unused register fields read as x0
    assign rd = use_rd ? instr[rd_lsb +: reg_addr_w] : '0;
    assign rs = use_rs ? instr[rs_lsb +: reg_addr_w] : '0;
    assign rt = use_rt ? instr[rt_lsb +: reg_addr_w] : '0;

    assign req = (use_rs ? req_rs : 2'b00) | (use_rt ? req_rt : 2'b00);

    assign csr  = instr[rt_lsb +: csr_w];
    assign sign = instr[xlen-1];

    always_comb begin
        unique case (fmt)
            fmt_i: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            fmt_s, fmt_b: begin
                // store and branch share the split field
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            fmt_u, fmt_j: begin
                imm = {{12{sign}}, instr[31:12]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       in_valid,
    input  fetch_pkt_t in_pkt,
    output logic       in_ready,
    output logic       out_valid,
    output dec_pkt_t   out_pkt,
    input  logic       out_ready
);

    logic                  fetch_valid;
    logic                  fetch_ready;
    fetch_pkt_t            fetch_pkt;
    instr_class_t          cls;
    fmt_t                  fmt;
    pipe_t                 pipe;
    logic [uop_w-1:0]      uop;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [1:0]            req;
    logic [xlen-1:0]       imm;
    logic [csr_w-1:0]      csr;
    dec_pkt_t              dec_pkt;

    pipe_slot #(.payload_t(fetch_pkt_t)) u_fetch_slot (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in_valid(in_valid), .in_pkt(in_pkt), .in_ready(in_ready),
        .out_valid(fetch_valid), .out_pkt(fetch_pkt), .out_ready(fetch_ready)
    );

    opcode_classify u_classify (.instr(fetch_pkt.instr), .cls(cls), .fmt(fmt));

    uop_map u_uop_map (.cls(cls), .instr(fetch_pkt.instr), .pipe(pipe), .uop(uop));

    operand_extract u_operands (
        .fmt(fmt), .instr(fetch_pkt.instr),
        .rd(rd), .rs(rs), .rt(rt), .req(req), .imm(imm), .csr(csr)
    );

    // pc rides along unchanged
    assign dec_pkt = '{pipe: pipe, uop: uop, rd: rd, rs: rs, rt: rt, req: req,
                       imm: imm, csr: csr, pc: fetch_pkt.pc, cls: cls, fmt: fmt};

    pipe_slot #(.payload_t(dec_pkt_t)) u_dec_slot (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in_valid(fetch_valid), .in_pkt(dec_pkt), .in_ready(fetch_ready),
        .out_valid(out_valid), .out_pkt(out_pkt), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== tb_decode_tasks.svh ====
task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors = errors + 1;
    end
endtask

task automatic check_pkt(input dec_pkt_t got, input dec_pkt_t exp);
    check("pipe", 128'(got.pipe), 128'(exp.pipe));
    check("uop", 128'(got.uop), 128'(exp.uop));
    check("rd", 128'(got.rd), 128'(exp.rd));
    check("rs", 128'(got.rs), 128'(exp.rs));
    check("rt", 128'(got.rt), 128'(exp.rt));
    check("req", 128'(got.req), 128'(exp.req));
    check("imm", 128'(got.imm), 128'(exp.imm));
    check("csr", 128'(got.csr), 128'(exp.csr));
    check("pc", 128'(got.pc), 128'(exp.pc));
    check("cls", 128'(got.cls), 128'(exp.cls));
    check("fmt", 128'(got.fmt), 128'(exp.fmt));
endtask

function automatic logic [31:0] mk(input logic [6:0] f7, input logic [4:0] rt,
        input logic [4:0] rs, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
    return {f7, rt, rs, f3, rd, op};
endfunction

function automatic logic [31:0] rand_instr();
    logic [31:0] r;
    logic [31:0] k;
    logic [6:0]  op;
    logic [6:0]  f7;
    r = $random(seed);
    k = $random(seed);
    case (k[3:0])
        4'd0: op = op_reg;
        4'd1: op = op_imm;
        4'd2: op = op_auipc;
        4'd3: op = op_jal;
        4'd4: op = op_jalr;
        4'd5: op = op_branch;
        4'd6: op = op_lui;
        4'd7: op = op_load;
        4'd8: op = op_store;
        4'd9: op = op_misc_mem;
        4'd10: op = op_system;
        default: op = r[6:0];
    endcase
    case (k[5:4])
        2'd0: f7 = 7'b0000000;
        2'd1: f7 = 7'b0100000;
        2'd2: f7 = 7'b0000001;
        default: f7 = r[31:25];
    endcase
    return {f7, r[24:7], op};
endfunction

// offer one instruction and hold it until it is taken
task automatic send(input logic [31:0] instr, input logic [31:0] pc);
    in_valid <= 1'b1;
    in_pkt <= '{instr: instr, pc: pc};
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    in_valid <= 1'b0;
endtask

// the last accepted item reaches the queue at the edge it is taken
task automatic drain();
    @(posedge clk);
    while (exp_q.size() != 0 || out_valid) @(posedge clk);
endtask

task automatic test_reset();
    check("out_valid", 128'(out_valid), 128'(0));
    check("in_ready", 128'(in_ready), 128'(1));
endtask

task automatic test_classes();
    logic [31:0] list[20];
    list = '{mk(7'h00, 3, 2, 0, 1, op_reg), mk(7'h20, 3, 2, 0, 1, op_reg),
             mk(7'h20, 3, 2, 5, 1, op_reg), mk(7'h01, 3, 2, 1, 1, op_reg),
             mk(7'h01, 3, 2, 6, 1, op_reg), mk(7'h02, 3, 2, 0, 1, op_reg),
             mk(7'h05, 3, 2, 2, 1, op_imm), mk(7'h20, 3, 2, 5, 1, op_imm),
             mk(7'h12, 3, 2, 4, 1, op_auipc), mk(7'h33, 3, 2, 4, 1, op_jal),
             mk(7'h00, 4, 2, 0, 1, op_jalr), mk(7'h00, 3, 2, 1, 8, op_branch),
             mk(7'h01, 3, 2, 7, 1, op_lui), mk(7'h00, 4, 2, 2, 1, op_load),
             mk(7'h00, 3, 2, 2, 9, op_store), mk(7'h00, 0, 0, 0, 0, op_misc_mem),
             32'h0000_0073, 32'h0010_0073, mk(7'h18, 5, 2, 1, 1, op_system),
             mk(7'h00, 3, 2, 0, 1, 7'h7f)};
    lat_check = 1'b1;
    foreach (list[n]) send(list[n], 32'h1000 + 4 * n);
    drain();
    lat_check = 1'b0;
endtask

task automatic test_formats();
    logic [31:0] r;
    logic [6:0]  ops[6];
    ops = '{op_reg, op_imm, op_store, op_branch, op_auipc, op_jal};
    foreach (ops[n]) begin
        r = $random(seed);
        send(mk(ops[n] == op_reg ? 7'h00 : {1'b1, r[31:26]}, r[4:0], r[9:5],
                r[12:10], r[17:13], ops[n]), r);
    end
    drain();
endtask

task automatic test_backpressure();
    logic [31:0] r;
    rand_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
        r = $random(seed);
        if (r[0]) @(posedge clk);
        send(rand_instr(), 32'h8000 + 4 * n);
    end
    rand_ready = 1'b0;
    out_ready <= 1'b1;
    drain();
endtask

task automatic test_flush();
    out_ready <= 1'b0;
    send(mk(7'h00, 3, 2, 0, 1, op_reg), 32'h100);
    send(mk(7'h00, 5, 4, 0, 6, op_imm), 32'h104);
    @(posedge clk);
    check("in_ready", 128'(in_ready), 128'(0));
    // an instruction offered during the flush must not be taken
    flush <= 1'b1;
    in_valid <= 1'b1;
    in_pkt <= '{instr: mk(7'h00, 1, 1, 0, 1, op_load), pc: 32'h108};
    @(posedge clk);
    flush <= 1'b0;
    in_valid <= 1'b0;
    @(posedge clk);
    check("out_valid", 128'(out_valid), 128'(0));
    out_ready <= 1'b1;
    send(mk(7'h00, 7, 6, 2, 5, op_load), 32'h200);
    send(mk(7'h01, 7, 6, 4, 5, op_reg), 32'h204);
    drain();
endtask

// ==== tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode import decode_pkg::*; ();

    localparam int max_cycles = 4000;

    logic       clk;
    logic       arst_n;
    logic       flush;
    logic       in_valid;
    fetch_pkt_t in_pkt;
    logic       in_ready;
    logic       out_valid;
    dec_pkt_t   out_pkt;
    logic       out_ready;

    integer     seed = 32'heed38a48;
    int         errors;
    int         cycles;
    logic       lat_check;
    logic       rand_ready;
    logic       prev_hold;
    dec_pkt_t   prev_pkt;
    logic [31:0] rnd;
    dec_pkt_t   exp_q[$];
    int         acc_q[$];

    decode_stage DUT (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in_valid(in_valid), .in_pkt(in_pkt), .in_ready(in_ready),
        .out_valid(out_valid), .out_pkt(out_pkt), .out_ready(out_ready)
    );

    `include "tb_decode_tasks.svh"

    // expected decode result, built straight from the instruction rules
    function automatic dec_pkt_t model(input logic [31:0] i, input logic [31:0] pc);
        dec_pkt_t   p;
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [2:0] grp;
        logic [2:0] low;
        p = '0;
        op = i[6:0];
        f3 = i[14:12];
        f7 = i[31:25];
        case (op)
            op_reg: begin
                if (f7 == 7'b0000000) p.cls = cls_alu;
                else if (f7 == 7'b0100000) p.cls = cls_alu_alt;
                else if (f7 == 7'b0000001) p.cls = (f3 >= 3'd4) ? cls_div : cls_mul;
                else p.cls = cls_illegal;
            end
            op_imm: begin
                if (f3 == 3'd5 && f7 == 7'b0100000) p.cls = cls_sra_imm;
                else p.cls = cls_alu_imm;
            end
            op_auipc: p.cls = cls_auipc;
            op_jal: p.cls = cls_jal;
            op_jalr: p.cls = cls_jalr;
            op_branch: p.cls = cls_branch;
            op_lui: p.cls = cls_lui;
            op_load: p.cls = cls_load;
            op_store: p.cls = cls_store;
            op_misc_mem: p.cls = cls_fence;
            op_system: p.cls = cls_system;
            default: p.cls = cls_illegal;
        endcase
        case (p.cls)
            cls_store: p.fmt = fmt_s;
            cls_branch: p.fmt = fmt_b;
            cls_auipc: p.fmt = fmt_u;
            cls_jal: p.fmt = fmt_j;
            cls_alu, cls_alu_alt, cls_mul, cls_div, cls_illegal: p.fmt = fmt_r;
            default: p.fmt = fmt_i;
        endcase
        p.pipe = pipe_x;
        grp = 3'd0;
        low = f3;
        case (p.cls)
            cls_alu_alt: begin
                grp = 3'd1;
                low = (f3 == 3'd0) ? 3'd4 : 3'd5;
            end
            cls_mul: grp = 3'd1;
            cls_alu_imm: grp = 3'd2;
            cls_sra_imm: begin
                grp = 3'd3;
                low = 3'd2;
            end
            cls_branch: grp = 3'd3;
            cls_auipc: {grp, low} = {3'd4, 3'd0};
            cls_jal: {grp, low} = {3'd4, 3'd1};
            cls_jalr: {grp, low} = {3'd4, 3'd2};
            cls_div: p.pipe = pipe_d;
            cls_load: p.pipe = pipe_l;
            cls_lui: begin
                p.pipe = pipe_l;
                low = 3'd3;
            end
            cls_store: begin
                p.pipe = pipe_l;
                grp = 3'd1;
            end
            cls_fence: begin
                p.pipe = pipe_l;
                grp = 3'd2;
            end
            cls_system: begin
                p.pipe = pipe_c;
                if (f3 == 3'd0) low = (i[31:20] == 12'd1) ? 3'd1 : 3'd0;
                else grp = 3'd1;
            end
            default: grp = 3'd0;
        endcase
        p.uop = (p.cls == cls_illegal) ? 6'd63 : {grp, low};
        if (p.fmt != fmt_s && p.fmt != fmt_b) p.rd = i[11:7];
        if (p.fmt != fmt_u && p.fmt != fmt_j) p.rs = i[19:15];
        if (p.fmt == fmt_r || p.fmt == fmt_s || p.fmt == fmt_b) p.rt = i[24:20];
        p.req = {p.fmt == fmt_r || p.fmt == fmt_s || p.fmt == fmt_b,
                 p.fmt != fmt_u && p.fmt != fmt_j};
        case (p.fmt)
            fmt_i: p.imm = {{20{i[31]}}, i[31:20]};
            fmt_s, fmt_b: p.imm = {{20{i[31]}}, i[31:25], i[11:7]};
            fmt_u, fmt_j: p.imm = {{12{i[31]}}, i[31:12]};
            default: p.imm = '0;
        endcase
        p.csr = i[31:20];
        p.pc = pc;
        return p;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // scoreboard, stability check and timeout
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (arst_n) begin
            if (prev_hold) check_pkt(out_pkt, prev_pkt);
            prev_hold = out_valid && !out_ready && !flush;
            prev_pkt = out_pkt;
            if (flush) begin
                exp_q.delete();
                acc_q.delete();
            end else begin
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("unexpected output packet at %0t", $time);
                        errors = errors + 1;
                    end else begin
                        check_pkt(out_pkt, exp_q.pop_front());
                        if (lat_check) check("latency", 128'(cycles - acc_q[0]), 128'(2));
                        void'(acc_q.pop_front());
                    end
                end
                if (in_valid && in_ready) begin
                    exp_q.push_back(model(in_pkt.instr, in_pkt.pc));
                    acc_q.push_back(cycles);
                end
            end
        end
        if (rand_ready) begin
            rnd = $random(seed);
            out_ready <= rnd[0];
        end
        if (cycles >= max_cycles) begin
            $display("timeout, the run did not finish within %0d cycles, error count %0d",
                     max_cycles, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        errors = 0;
        cycles = 0;
        lat_check = 1'b0;
        rand_ready = 1'b0;
        prev_hold = 1'b0;
        prev_pkt = '0;
        arst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        out_ready = 1'b1;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        test_reset();
        test_classes();
        test_formats();
        test_backpressure();
        test_flush();
        $display("checks done, error count %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
decode_pkg.sv
pipe_slot.sv
opcode_classify.sv
uop_map.sv
operand_extract.sv
decode_stage.sv
tb_decode.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_decode -o sim_decode
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
